/* Bender.yml */
package:
  name: fb_frame_buffer

sources:
  - include_dirs:
      - source
    files:
      - source/fb_pkg.sv
      - source/fb_reg_slice.sv
      - source/fb_frame_ring.sv
      - source/fb_write_stage.sv
      - source/fb_read_stage.sv
      - source/fb_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/fb_mem_model.sv
      - dv/tb_fb_top.sv

/* all.f */
+incdir+source
source/fb_pkg.sv
source/fb_reg_slice.sv
source/fb_frame_ring.sv
source/fb_write_stage.sv
source/fb_read_stage.sv
source/fb_top.sv
dv/fb_mem_model.sv
dv/tb_fb_top.sv

/* dv/fb_mem_model.sv */
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  fb_pkg::fb_wr_req_t    wr,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  logic [`FB_ADDR_W-1:0] ar_addr,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output logic [`FB_WORD_W-1:0] rdata,
    output logic                  rdata_valid,
    input  logic                  rdata_ready
);
    logic [7:0]            mem [logic [`FB_ADDR_W-1:0]];  // sparse, byte addressed
    logic [`FB_ADDR_W-1:0] rq_addr [$];
    int                    rq_due [$];  // cycle at which the word may return
    int                    cyc = 0;
    logic                  rsent = 1'b0;

    initial
    begin
        wr_ready    = 1'b0;
        ar_ready    = 1'b0;
        rdata       = '0;
        rdata_valid = 1'b0;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (reset)
        begin
            rq_addr.delete();
            rq_due.delete();
        end
        else
        begin
            if (wr_valid && wr_ready)
            begin
                for (int b = 0; b < 4; b++)
                    mem[wr.addr + b] = wr.data.lane[b];  // commit at transfer
            end
            if (ar_valid && ar_ready)
            begin
                rq_addr.push_back(ar_addr);
                rq_due.push_back(cyc + $urandom % 4);
            end
            if (rdata_valid && rdata_ready)
                rsent = 1'b1;
        end
    end

    always @(negedge clk)
    begin
        wr_ready = ($urandom % 4) != 0;
        ar_ready = ($urandom % 3) != 0;
        if (reset)
        begin
            rdata_valid = 1'b0;
            rsent       = 1'b0;
        end
        else if (!rdata_valid || rsent)
        begin
            rsent = 1'b0;
            if (rq_addr.size() > 0 && rq_due[0] <= cyc)
            begin
                for (int b = 0; b < 4; b++)
                    rdata[8*b +: 8] = mem[rq_addr[0] + b];
                rdata_valid = 1'b1;
                void'(rq_addr.pop_front());
                void'(rq_due.pop_front());
            end
            else
                rdata_valid = 1'b0;
        end
    end

endmodule

/* dv/tb_fb_top.sv */
`timescale 1ns/1ps
`include "fb_defines.svh"

module tb_fb_top;
    localparam int N_FRAMES = 12;
    localparam int TIMEOUT  = 5000;

    logic clk = 1'b0;
    logic reset, disp_suspend, rd_new_frame;
    logic [`FB_PIX_W-1:0] s_pix;
    logic s_pix_valid, s_pix_ready, m_pix_valid, m_pix_ready;
    fb_pkg::fb_pix_out_t m_pix;
    fb_pkg::fb_wr_req_t  mem_wr;
    logic mem_wr_valid, mem_wr_ready, mem_ar_valid, mem_ar_ready;
    logic mem_rdata_valid, mem_rdata_ready;
    logic [`FB_ADDR_W-1:0] mem_ar_addr;
    logic [`FB_WORD_W-1:0] mem_rdata;

    // reference model of the frame ring and the output stream
    logic [`FB_SLOT_W-1:0] m_wr_slot, m_newest, m_rd_slot, rd_nxt_c, wr_step_c, wr_next_c;
    logic m_any_done, m_started, m_reader_idle;
    logic wr_fire, wr_done_c, grant_c, take_c, pix_fire, ar_fire, exp_last;
    logic [`FB_PIX_W-1:0]  pix_table [`FB_FRAME_N][`FB_FRAME_PIX];
    logic [`FB_PIX_W-1:0]  exp_pix;
    logic [`FB_ADDR_W-1:0] exp_addr;
    logic [`FB_ADDR_W-1:0] exp_ar_addr;
    fb_pkg::fb_word_u      exp_word;
    int wr_word_cnt, out_idx, out_frames, credits;
    int ar_cnt;  // read words issued in the current frame
    int err_cnt = 0;

    fb_top dut0 (.*);

    fb_mem_model mem0 (
        .clk (clk), .reset (reset),
        .wr (mem_wr), .wr_valid (mem_wr_valid), .wr_ready (mem_wr_ready),
        .ar_addr (mem_ar_addr), .ar_valid (mem_ar_valid), .ar_ready (mem_ar_ready),
        .rdata (mem_rdata), .rdata_valid (mem_rdata_valid), .rdata_ready (mem_rdata_ready)
    );

    initial
    begin
        forever #2 clk = ~clk;
    end

    function automatic logic [`FB_SLOT_W-1:0] ring_next(input logic [`FB_SLOT_W-1:0] s);
        return (s == `FB_FRAME_N - 1) ? '0 : s + 1'b1;
    endfunction

    always_comb
    begin
        wr_fire   = mem_wr_valid && mem_wr_ready;
        wr_done_c = wr_fire && (wr_word_cnt % `FB_FRAME_WORDS == `FB_FRAME_WORDS - 1);
        grant_c   = m_reader_idle && m_any_done;
        take_c    = grant_c && (!m_started || (!disp_suspend && m_newest != m_rd_slot));
        rd_nxt_c  = take_c ? m_newest : m_rd_slot;
        wr_step_c = ring_next(m_wr_slot);
        wr_next_c = ((m_started || grant_c) && wr_step_c == rd_nxt_c)
                  ? ring_next(wr_step_c) : wr_step_c;
        exp_addr  = `FB_BASE_ADDR + m_wr_slot * `FB_FRAME_BYTES
                  + (wr_word_cnt % `FB_FRAME_WORDS) * 4;
        for (int j = 0; j < `FB_PIX_PER_WORD; j++)
            exp_word.lane[j] = 8'(wr_word_cnt * 4 + j);  // frame*64 + index, mod 256
        pix_fire = m_pix_valid && m_pix_ready;
        ar_fire  = mem_ar_valid && mem_ar_ready;
        exp_ar_addr = `FB_BASE_ADDR + m_rd_slot * `FB_FRAME_BYTES + ar_cnt * 4;
        exp_last = out_idx == `FB_FRAME_PIX - 1;
        exp_pix  = pix_table[m_rd_slot][out_idx];
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            m_wr_slot     <= '0;
            m_newest      <= '0;
            m_rd_slot     <= '0;
            m_any_done    <= 1'b0;
            m_started     <= 1'b0;
            m_reader_idle <= 1'b1;
            wr_word_cnt   <= 0;
            out_idx       <= 0;
            out_frames    <= 0;
            credits       <= 0;
            ar_cnt        <= 0;
        end
        else
        begin
            if (wr_fire)
            begin
                wr_word_cnt <= wr_word_cnt + 1;
                for (int j = 0; j < `FB_PIX_PER_WORD; j++)
                    pix_table[m_wr_slot][(wr_word_cnt % `FB_FRAME_WORDS) * 4 + j]
                        <= exp_word.lane[j];
            end
            if (wr_done_c)
            begin
                m_newest   <= m_wr_slot;
                m_any_done <= 1'b1;
                m_wr_slot  <= wr_next_c;
            end
            if (grant_c)
            begin
                m_started     <= 1'b1;
                m_rd_slot     <= rd_nxt_c;
                m_reader_idle <= 1'b0;
            end
            else if (pix_fire && exp_last)
                m_reader_idle <= 1'b1;  // frame fully out
            if (grant_c)
                ar_cnt <= 0;
            else if (ar_fire)
                ar_cnt <= ar_cnt + 1;
            if (pix_fire)
            begin
                out_idx <= exp_last ? 0 : out_idx + 1;
                if (exp_last)
                    out_frames <= out_frames + 1;
            end
            credits <= credits + int'(ar_fire) - int'(pix_fire && out_idx % 4 == 3);
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_cnt++;
        $display("Error: %s got %0h expected %0h", name, got, exp);
    endtask

    task automatic flag_failure(input string what);
        err_cnt++;
        $display("%s", what);
    endtask

    a_wr_addr: assert property (@(posedge clk) disable iff (reset)
        wr_fire |-> mem_wr.addr == exp_addr)
        else report_mismatch("mem_wr.addr", $sampled(mem_wr.addr), $sampled(exp_addr));
    a_wr_data: assert property (@(posedge clk) disable iff (reset)
        wr_fire |-> mem_wr.data == exp_word)
        else report_mismatch("mem_wr.data", $sampled(mem_wr.data), $sampled(exp_word));
    a_rd_addr: assert property (@(posedge clk) disable iff (reset)
        ar_fire |-> mem_ar_addr == exp_ar_addr)
        else report_mismatch("mem_ar_addr", $sampled(mem_ar_addr), $sampled(exp_ar_addr));
    a_pix: assert property (@(posedge clk) disable iff (reset)
        m_pix_valid |-> m_pix.pix == exp_pix)
        else report_mismatch("m_pix.pix", $sampled(m_pix.pix), $sampled(exp_pix));
    a_slot: assert property (@(posedge clk) disable iff (reset)
        m_pix_valid |-> m_pix.slot == m_rd_slot)
        else report_mismatch("m_pix.slot", $sampled(m_pix.slot), $sampled(m_rd_slot));
    a_last: assert property (@(posedge clk) disable iff (reset)
        m_pix_valid |-> m_pix.last == exp_last)
        else report_mismatch("m_pix.last", $sampled(m_pix.last), $sampled(exp_last));
    a_new: assert property (@(posedge clk) disable iff (reset)
        rd_new_frame == take_c)
        else report_mismatch("rd_new_frame", $sampled(rd_new_frame), $sampled(take_c));
    a_suspend: assert property (@(posedge clk) disable iff (reset)
        rd_new_frame && m_started |-> !disp_suspend)
        else flag_failure("rd_new_frame pulsed while the display was suspended");
    a_credit: assert property (@(posedge clk) disable iff (reset)
        credits <= `FB_RD_CREDITS)
        else flag_failure("more read words outstanding than the credit limit");
    a_not_wr: assert property (@(posedge clk) disable iff (reset)
        m_pix_valid |-> m_pix.slot != m_wr_slot)
        else flag_failure("output shows the slot currently being written");
    a_reset: assert property (@(posedge clk) $fell(reset) |-> !m_pix_valid && !mem_wr_valid
                              && !mem_ar_valid && !rd_new_frame)
        else flag_failure("outputs not idle right after reset");

    always @(negedge clk)
        m_pix_ready = ($urandom % 4) != 0;

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic send_pixel(input logic [`FB_PIX_W-1:0] value);
        int t;
        repeat ($urandom % 3) @(negedge clk);  // random gap
        s_pix       = value;
        s_pix_valid = 1'b1;
        t = 0;
        do
        begin
            @(posedge clk);
            t++;
        end
        while (!s_pix_ready && t < TIMEOUT);
        if (!s_pix_ready)
            abort_on_timeout("s_pix_ready");
        else
        begin
            @(negedge clk);
            s_pix_valid = 1'b0;
        end
    endtask

    initial
    begin
        int t;
        int target;
        void'($urandom(5127));
        reset        = 1'b1;
        disp_suspend = 1'b0;
        s_pix        = '0;
        s_pix_valid  = 1'b0;
        m_pix_ready  = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int f = 0; f < N_FRAMES; f++)
        begin
            disp_suspend = (f >= 5 && f < 8);  // hold across a few frame starts
            for (int k = 0; k < `FB_FRAME_PIX; k++)
                send_pixel(8'(f * `FB_FRAME_PIX + k));
        end
        disp_suspend = 1'b0;
        target = out_frames + 2;
        t = 0;
        while (out_frames < target && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (out_frames < target)
            abort_on_timeout("output frames");
        else
        begin
            repeat (4) @(negedge clk);
            $display("Run complete: %0d output frames, %0d errors", out_frames, err_cnt);
            if (err_cnt == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end

endmodule

/* source/fb_defines.svh */
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// pixel and memory word geometry
`define FB_PIX_W        8
`define FB_PIX_PER_WORD 4
`define FB_WORD_W       32
`define FB_ADDR_W       32

// one frame, as pixels, words and bytes
`define FB_FRAME_PIX    64
`define FB_FRAME_WORDS  16
`define FB_FRAME_BYTES  64

// ring of frame slots
`define FB_FRAME_N      4
`define FB_SLOT_W       2
`define FB_BASE_ADDR    32'h1000

`define FB_RD_CREDITS   4    // read words in flight or buffered

`endif

/* source/fb_frame_ring.sv */
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_frame_ring (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  disp_suspend,
    input  logic                  wr_frame_done,
    output logic [`FB_SLOT_W-1:0] wr_slot,
    input  logic                  rd_frame_start,
    output logic                  rd_grant,
    output logic [`FB_SLOT_W-1:0] rd_slot,
    output logic                  rd_new_frame
);
    logic [`FB_SLOT_W-1:0] wr_slot_q;
    logic [`FB_SLOT_W-1:0] newest_q;      // last completed slot
    logic [`FB_SLOT_W-1:0] rd_slot_q;
    logic                  any_done_q;
    logic                  rd_started_q;  // a frame has been handed to the reader
    logic                  rd_take;
    logic [`FB_SLOT_W-1:0] rd_slot_nxt;
    logic [`FB_SLOT_W-1:0] wr_step;

    function automatic logic [`FB_SLOT_W-1:0] next_slot(input logic [`FB_SLOT_W-1:0] s);
        if (s == `FB_SLOT_W'(`FB_FRAME_N - 1))
            return '0;
        return s + 1'b1;
    endfunction

    assign rd_grant = rd_frame_start && any_done_q;

    // switch to the newest frame unless held; first frame always taken
    assign rd_take = rd_grant
                  && (!rd_started_q || (!disp_suspend && newest_q != rd_slot_q));
    assign rd_slot_nxt = rd_take ? newest_q : rd_slot_q;
    assign wr_step     = next_slot(wr_slot_q);

    assign wr_slot      = wr_slot_q;
    assign rd_slot      = rd_slot_nxt;
    assign rd_new_frame = rd_take;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_slot_q    <= '0;
            newest_q     <= '0;
            rd_slot_q    <= '0;
            any_done_q   <= 1'b0;
            rd_started_q <= 1'b0;
        end
        else
        begin
            if (wr_frame_done)
            begin
                newest_q   <= wr_slot_q;
                any_done_q <= 1'b1;
                // never land on the slot on display
                if ((rd_started_q || rd_grant) && wr_step == rd_slot_nxt)
                    wr_slot_q <= next_slot(wr_step);
                else
                    wr_slot_q <= wr_step;
            end
            if (rd_grant)
            begin
                rd_started_q <= 1'b1;
                rd_slot_q    <= rd_slot_nxt;
            end
        end
    end

endmodule

/* source/fb_pkg.sv */
`include "fb_defines.svh"

package fb_pkg;

    // one memory word, seen whole or as pixel lanes
    typedef union packed {
        logic [`FB_WORD_W-1:0]                      word;
        logic [`FB_PIX_PER_WORD-1:0][`FB_PIX_W-1:0] lane;  // lane 0 in low byte
    } fb_word_u;

    // single word write to memory
    typedef struct packed {
        logic [`FB_ADDR_W-1:0] addr;
        fb_word_u              data;
    } fb_wr_req_t;

    // output stream beat
    typedef struct packed {
        logic [`FB_PIX_W-1:0]  pix;
        logic [`FB_SLOT_W-1:0] slot;  // frame slot the pixel came from
        logic                  last;  // last pixel of the frame
    } fb_pix_out_t;

endpackage

/* source/fb_read_stage.sv */
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_read_stage (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  rd_frame_start,
    input  logic                  rd_grant,
    input  logic [`FB_SLOT_W-1:0] rd_slot,
    output logic [`FB_ADDR_W-1:0] ar_addr,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    input  fb_pkg::fb_word_u      rdata,
    input  logic                  rdata_valid,
    output logic                  rdata_ready,
    output fb_pkg::fb_pix_out_t   pix_out,
    output logic                  pix_valid,
    input  logic                  pix_ready
);
    localparam int PTR_W   = $clog2(`FB_RD_CREDITS);
    localparam int CNT_W   = $clog2(`FB_RD_CREDITS + 1);
    localparam int ISSUE_W = $clog2(`FB_FRAME_WORDS + 1);
    localparam int PCNT_W  = $clog2(`FB_FRAME_PIX);
    localparam int LANE_W  = $clog2(`FB_PIX_PER_WORD);

    fb_pkg::fb_word_u      buf_mem [`FB_RD_CREDITS];
    logic [PTR_W-1:0]      buf_wr_ptr;
    logic [PTR_W-1:0]      buf_rd_ptr;
    logic [CNT_W-1:0]      buf_cnt_q;
    logic [CNT_W-1:0]      credit_q;     // issued but not yet unpacked
    logic                  frame_act_q;
    logic [`FB_SLOT_W-1:0] slot_q;
    logic [ISSUE_W-1:0]    issue_cnt_q;
    logic [PCNT_W-1:0]     pix_cnt_q;    // pixel index within the frame
    logic [LANE_W-1:0]     lane_sel;
    logic                  ar_fire;
    logic                  rd_fire;
    logic                  pix_fire;
    logic                  word_done;

    assign rd_frame_start = !frame_act_q;  // idle until the whole frame is out

    assign ar_valid = frame_act_q && issue_cnt_q < `FB_FRAME_WORDS
                   && credit_q < `FB_RD_CREDITS;
    assign ar_addr  = `FB_ADDR_W'(`FB_BASE_ADDR)
                    + `FB_ADDR_W'(slot_q) * `FB_FRAME_BYTES
                    + `FB_ADDR_W'(issue_cnt_q) * (`FB_WORD_W / 8);
    assign ar_fire  = ar_valid && ar_ready;

    assign rdata_ready = buf_cnt_q < `FB_RD_CREDITS;
    assign rd_fire     = rdata_valid && rdata_ready;

    assign lane_sel  = pix_cnt_q[LANE_W-1:0];
    assign pix_valid = buf_cnt_q != '0;
    assign pix_fire  = pix_valid && pix_ready;
    assign word_done = pix_fire && lane_sel == LANE_W'(`FB_PIX_PER_WORD - 1);

    always_comb
    begin
        pix_out.pix  = buf_mem[buf_rd_ptr].lane[lane_sel];  // low lane first
        pix_out.slot = slot_q;
        pix_out.last = pix_cnt_q == PCNT_W'(`FB_FRAME_PIX - 1);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            frame_act_q <= 1'b0;
            slot_q      <= '0;
            issue_cnt_q <= '0;
            pix_cnt_q   <= '0;
            credit_q    <= '0;
            buf_cnt_q   <= '0;
            buf_wr_ptr  <= '0;
            buf_rd_ptr  <= '0;
        end
        else
        begin
            if (rd_grant)
            begin
                frame_act_q <= 1'b1;
                slot_q      <= rd_slot;
                issue_cnt_q <= '0;
            end
            else if (pix_fire && pix_out.last)
            begin
                frame_act_q <= 1'b0;
            end

            if (ar_fire)
                issue_cnt_q <= issue_cnt_q + 1'b1;
            if (pix_fire)
                pix_cnt_q <= pix_out.last ? '0 : pix_cnt_q + 1'b1;
            if (rd_fire)
                buf_wr_ptr <= buf_wr_ptr + 1'b1;
            if (word_done)
                buf_rd_ptr <= buf_rd_ptr + 1'b1;

            case ({ar_fire, word_done})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: ;
            endcase
            case ({rd_fire, word_done})
                2'b10:   buf_cnt_q <= buf_cnt_q + 1'b1;
                2'b01:   buf_cnt_q <= buf_cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_fire)
            buf_mem[buf_wr_ptr] <= rdata;
    end

endmodule

/* source/fb_reg_slice.sv */
`timescale 1ns/1ps

module fb_reg_slice #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);
    logic [WIDTH-1:0] main_q;
    logic [WIDTH-1:0] skid_q;
    logic             main_valid_q;
    logic             skid_valid_q;
    logic             main_load;  // main register free this cycle
    logic             in_fire;

    assign main_load = out_ready || !main_valid_q;
    assign in_ready  = !skid_valid_q;  // straight from a flop
    assign in_fire   = in_valid && in_ready;
    assign out_data  = main_q;
    assign out_valid = main_valid_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end
        else if (main_load)
        begin
            // skid word goes first, otherwise take the input directly
            if (skid_valid_q)
                skid_valid_q <= 1'b0;
            main_valid_q <= skid_valid_q || in_valid;
        end
        else if (in_fire)
        begin
            skid_valid_q <= 1'b1;  // output stalled, park the word
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_load)
        begin
            if (skid_valid_q)
                main_q <= skid_q;
            else if (in_valid)
                main_q <= in_data;
        end
        else if (in_fire)
        begin
            skid_q <= in_data;
        end
    end

endmodule

/* source/fb_top.sv */
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  disp_suspend,
    output logic                  rd_new_frame,
    input  logic [`FB_PIX_W-1:0]  s_pix,
    input  logic                  s_pix_valid,
    output logic                  s_pix_ready,
    output fb_pkg::fb_pix_out_t   m_pix,
    output logic                  m_pix_valid,
    input  logic                  m_pix_ready,
    output fb_pkg::fb_wr_req_t    mem_wr,
    output logic                  mem_wr_valid,
    input  logic                  mem_wr_ready,
    output logic [`FB_ADDR_W-1:0] mem_ar_addr,
    output logic                  mem_ar_valid,
    input  logic                  mem_ar_ready,
    input  logic [`FB_WORD_W-1:0] mem_rdata,
    input  logic                  mem_rdata_valid,
    output logic                  mem_rdata_ready
);
    logic [`FB_SLOT_W-1:0] wr_slot;
    logic                  wr_frame_done;
    logic                  rd_frame_start;
    logic                  rd_grant;
    logic [`FB_SLOT_W-1:0] rd_slot;
    logic [`FB_WORD_W-1:0] rdata_s;  // read data after the slice
    logic                  rdata_s_valid;
    logic                  rdata_s_ready;

    fb_write_stage write_stage0 (
        .clk           (clk),
        .reset         (reset),
        .pix_in        (s_pix),
        .pix_valid     (s_pix_valid),
        .pix_ready     (s_pix_ready),
        .wr_slot       (wr_slot),
        .wr_req        (mem_wr),
        .wr_valid      (mem_wr_valid),
        .wr_ready      (mem_wr_ready),
        .wr_frame_done (wr_frame_done)
    );

    fb_frame_ring frame_ring0 (
        .clk            (clk),
        .reset          (reset),
        .disp_suspend   (disp_suspend),
        .wr_frame_done  (wr_frame_done),
        .wr_slot        (wr_slot),
        .rd_frame_start (rd_frame_start),
        .rd_grant       (rd_grant),
        .rd_slot        (rd_slot),
        .rd_new_frame   (rd_new_frame)
    );

    fb_reg_slice #(
        .WIDTH (`FB_WORD_W)
    ) rdata_slice0 (
        .clk       (clk),
        .reset     (reset),
        .in_data   (mem_rdata),
        .in_valid  (mem_rdata_valid),
        .in_ready  (mem_rdata_ready),
        .out_data  (rdata_s),
        .out_valid (rdata_s_valid),
        .out_ready (rdata_s_ready)
    );

    fb_read_stage read_stage0 (
        .clk            (clk),
        .reset          (reset),
        .rd_frame_start (rd_frame_start),
        .rd_grant       (rd_grant),
        .rd_slot        (rd_slot),
        .ar_addr        (mem_ar_addr),
        .ar_valid       (mem_ar_valid),
        .ar_ready       (mem_ar_ready),
        .rdata          (rdata_s),
        .rdata_valid    (rdata_s_valid),
        .rdata_ready    (rdata_s_ready),
        .pix_out        (m_pix),
        .pix_valid      (m_pix_valid),
        .pix_ready      (m_pix_ready)
    );

endmodule

/* source/fb_write_stage.sv */
`timescale 1ns/1ps
`include "fb_defines.svh"

module fb_write_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`FB_PIX_W-1:0]  pix_in,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    input  logic [`FB_SLOT_W-1:0] wr_slot,
    output fb_pkg::fb_wr_req_t    wr_req,
    output logic                  wr_valid,
    input  logic                  wr_ready,
    output logic                  wr_frame_done
);
    localparam int LANE_W = $clog2(`FB_PIX_PER_WORD);
    localparam int WCNT_W = $clog2(`FB_FRAME_WORDS);

    fb_pkg::fb_word_u   pack_q;
    fb_pkg::fb_word_u   pack_d;       // packed word including this pixel
    fb_pkg::fb_wr_req_t req_q;
    logic [LANE_W-1:0]  lane_q;
    logic [WCNT_W-1:0]  word_q;       // word index within the frame
    logic               req_valid_q;
    logic               req_last_q;
    logic               pix_fire;
    logic               wr_fire;
    logic               word_full;

    assign pix_ready = !req_valid_q || wr_ready;  // held off while a write is stalled
    assign pix_fire  = pix_valid && pix_ready;
    assign wr_fire   = req_valid_q && wr_ready;
    assign word_full = pix_fire && lane_q == LANE_W'(`FB_PIX_PER_WORD - 1);

    assign wr_req        = req_q;
    assign wr_valid      = req_valid_q;
    assign wr_frame_done = wr_fire && req_last_q;

    always_comb
    begin
        pack_d = pack_q;
        pack_d.lane[lane_q] = pix_in;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lane_q      <= '0;
            word_q      <= '0;
            req_valid_q <= 1'b0;
            req_last_q  <= 1'b0;
        end
        else
        begin
            if (pix_fire)
                lane_q <= word_full ? '0 : lane_q + 1'b1;
            if (word_full)
            begin
                req_valid_q <= 1'b1;
                req_last_q  <= word_q == WCNT_W'(`FB_FRAME_WORDS - 1);
                word_q      <= (word_q == WCNT_W'(`FB_FRAME_WORDS - 1)) ? '0 : word_q + 1'b1;
            end
            else if (wr_fire)
            begin
                req_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pix_fire)
            pack_q <= pack_d;
        if (word_full)
        begin
            req_q.addr <= `FB_ADDR_W'(`FB_BASE_ADDR)
                        + `FB_ADDR_W'(wr_slot) * `FB_FRAME_BYTES
                        + `FB_ADDR_W'(word_q) * (`FB_WORD_W / 8);
            req_q.data <= pack_d;
        end
    end

endmodule
